// File: saturnPkg.sv
`default_nettype none

package saturnPkg;

	// CPU bus
	localparam int cpuAddrWidth = 25;
	localparam int cpuDataWidth = 32;
	localparam int dqmWidth = cpuDataWidth / 8;

	// Peripheral buses
	localparam int bBusDataWidth = 16;
	localparam int smpcDataWidth = 8;

	// SMPC byte is mirrored on every lane of the CPU word
	localparam int smpcRepeat = cpuDataWidth / smpcDataWidth;

	// Rising-phase enables per SMPC enable
	localparam int smpcDivide = 7;
	localparam int smpcCntWidth = $clog2(smpcDivide);

	// Debug monitor
	localparam int waitCntWidth = 8;
	localparam logic [cpuAddrWidth-1:0] hookAddr = 25'h0012B0;

	// Master CPU bus outputs
	typedef struct packed {
		logic [cpuAddrWidth-1:0] addr;
		logic [cpuDataWidth-1:0] wrData;
		logic                    bsN;
		logic                    cs0N;
		logic                    cs1N;
		logic                    cs2N;
		logic                    cs3N;
		logic                    rdWrN;
		logic                    rdN;
		logic [dqmWidth-1:0]     dqmN;
	} cpuBusReqT;

	// Decoded enables from the bus controller, active low
	typedef struct packed {
		logic dramCeN;
		logic romCeN;
		logic sramCeN;
		logic smpcCeN;
	} chipSelT;

	// External memory port
	typedef struct packed {
		logic [cpuAddrWidth-1:0] addr;
		logic [cpuDataWidth-1:0] wrData;
		logic                    romCsN;
		logic                    sramCsN;
		logic                    ramLCsN;
		logic                    ramHCsN;
		logic [dqmWidth-1:0]     dqmN;
		logic                    rdN;
	} memPortT;

	// B-bus read selects, active low
	typedef struct packed {
		logic vdp1CsN;
		logic vdp2CsN;
		logic scspCsN;
	} bBusSelT;

endpackage

`default_nettype wire

// File: clockEnableGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockEnableGen (
	input  logic CLK,
	input  logic RST_N,
	input  logic ce,
	input  logic dbgPause,
	output logic ceR,
	output logic ceF,
	output logic smpcCe,
	output logic mresN
);
	import saturnPkg::*;

	logic                    phase;
	logic [smpcCntWidth-1:0] smpcCnt;
	logic                    smpcLast;

	// Master phase, frozen while paused
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			phase <= 1'b0;
		end else if (ce && !dbgPause) begin
			phase <= ~phase;
		end
	end

	assign ceR = phase & ~dbgPause;
	assign ceF = ~phase & ~dbgPause;

	assign smpcLast = (smpcCnt == smpcCntWidth'(smpcDivide - 1));

	// SMPC enable divider
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			smpcCnt <= '0;
			smpcCe <= 1'b0;
		end else begin
			smpcCe <= ceR & smpcLast;
			if (ceR) begin
				if (smpcLast) begin
					smpcCnt <= '0;
				end else begin
					smpcCnt <= smpcCnt + 1'b1;
				end
			end
		end
	end

	// Master reset released by the first SMPC enable
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mresN <= 1'b0;
		end else if (smpcCe) begin
			mresN <= 1'b1;
		end
	end

	// SMPC enable is a single-cycle strobe
	smpcCeSingle: assert property (
		@(posedge CLK) disable iff (!RST_N)
		smpcCe |=> !smpcCe
	);

endmodule

`default_nettype wire

// File: busReadSteer.sv
`timescale 1ns/10ps
`default_nettype none

module busReadSteer (
	input  saturnPkg::cpuBusReqT                cpuBusReq,
	input  saturnPkg::chipSelT                  chipSel,
	input  logic [saturnPkg::cpuDataWidth-1:0]  memRdData,
	input  logic [saturnPkg::cpuDataWidth-1:0]  scuRdData,
	input  logic [saturnPkg::smpcDataWidth-1:0] smpcRdData,
	input  logic                                memWaitN,
	input  logic                                scuWaitN,
	input  saturnPkg::bBusSelT                  bBusSel,
	input  logic [saturnPkg::bBusDataWidth-1:0] vdp1RdData,
	input  logic [saturnPkg::bBusDataWidth-1:0] vdp2RdData,
	input  logic [saturnPkg::bBusDataWidth-1:0] scspRdData,
	output saturnPkg::memPortT                  memPort,
	output logic [saturnPkg::cpuDataWidth-1:0]  cpuRdData,
	output logic                                cpuWaitN,
	output logic [saturnPkg::bBusDataWidth-1:0] bBusRdData
);
	import saturnPkg::*;

	logic memSel;
	logic [cpuDataWidth-1:0] smpcWord;

	// Any access that lands in external memory
	assign memSel = !cpuBusReq.cs3N || !chipSel.dramCeN ||
	                !chipSel.romCeN || !chipSel.sramCeN;

	assign smpcWord = {smpcRepeat{smpcRdData}};

	// CPU read data priority: memory, SMPC, SCU
	always_comb begin
		if (memSel) begin
			cpuRdData = memRdData;
		end else if (!chipSel.smpcCeN) begin
			cpuRdData = smpcWord;
		end else begin
			cpuRdData = scuRdData;
		end
	end

	// Memory wait only counts while memory is selected
	assign cpuWaitN = scuWaitN & (memWaitN | ~memSel);

	// External memory port
	always_comb begin
		memPort.addr    = cpuBusReq.addr;
		memPort.wrData  = cpuBusReq.wrData;
		memPort.dqmN    = cpuBusReq.dqmN;
		memPort.rdN     = cpuBusReq.rdN;
		memPort.romCsN  = chipSel.romCeN;
		memPort.sramCsN = chipSel.sramCeN;
		// Low work RAM on the DRAM enable, high work RAM on CS3
		memPort.ramLCsN = chipSel.dramCeN;
		memPort.ramHCsN = cpuBusReq.cs3N;
	end

	// B-bus read mux toward the SCU
	always_comb begin
		if (!bBusSel.vdp1CsN) begin
			bBusRdData = vdp1RdData;
		end else if (!bBusSel.vdp2CsN) begin
			bBusRdData = vdp2RdData;
		end else if (!bBusSel.scspCsN) begin
			bBusRdData = scspRdData;
		end else begin
			bBusRdData = '0;
		end
	end

endmodule

`default_nettype wire

// File: busActivityMonitor.sv
`timescale 1ns/10ps
`default_nettype none

module busActivityMonitor (
	input  logic                               CLK,
	input  logic                               RST_N,
	input  logic                               ceR,
	input  saturnPkg::cpuBusReqT               cpuBusReq,
	output logic [saturnPkg::waitCntWidth-1:0] waitCnt,
	output logic                               hook
);
	import saturnPkg::*;

	logic busAccess;
	logic hookHit;

	// Read strobe or any byte lane written
	assign busAccess = !cpuBusReq.rdN || (cpuBusReq.dqmN != '1);

	assign hookHit = (cpuBusReq.addr == hookAddr) &&
	                 !cpuBusReq.rdN && !cpuBusReq.cs3N;

	// Idle time in rising-phase enables, wraps on overflow
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			waitCnt <= '0;
		end else if (ceR) begin
			if (busAccess) begin
				waitCnt <= '0;
			end else begin
				waitCnt <= waitCnt + 1'b1;
			end
		end
	end

	// Sticky until reset
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			hook <= 1'b0;
		end else if (ceR && hookHit) begin
			hook <= 1'b1;
		end
	end

	hookSticky: assert property (
		@(posedge CLK) disable iff (!RST_N)
		hook |=> hook
	);

endmodule

`default_nettype wire

// File: saturnGlue.sv
`timescale 1ns/10ps
`default_nettype none

module saturnGlue (
	input  logic                                CLK,
	input  logic                                RST_N,

	input  logic                                ce,
	input  logic                                dbgPause,
	output logic                                ceR,
	output logic                                ceF,
	output logic                                smpcCe,
	output logic                                mresN,

	input  saturnPkg::cpuBusReqT                cpuBusReq,
	input  saturnPkg::chipSelT                  chipSel,
	input  logic [saturnPkg::cpuDataWidth-1:0]  memRdData,
	input  logic [saturnPkg::cpuDataWidth-1:0]  scuRdData,
	input  logic [saturnPkg::smpcDataWidth-1:0] smpcRdData,
	input  logic                                memWaitN,
	input  logic                                scuWaitN,
	output saturnPkg::memPortT                  memPort,
	output logic [saturnPkg::cpuDataWidth-1:0]  cpuRdData,
	output logic                                cpuWaitN,

	input  saturnPkg::bBusSelT                  bBusSel,
	input  logic [saturnPkg::bBusDataWidth-1:0] vdp1RdData,
	input  logic [saturnPkg::bBusDataWidth-1:0] vdp2RdData,
	input  logic [saturnPkg::bBusDataWidth-1:0] scspRdData,
	output logic [saturnPkg::bBusDataWidth-1:0] bBusRdData,

	output logic [saturnPkg::waitCntWidth-1:0]  waitCnt,
	output logic                                hook
);

	// Clock enables, SMPC enable and master reset release
	clockEnableGen u_clockEnableGen (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.ce       (ce),
		.dbgPause (dbgPause),
		.ceR      (ceR),
		.ceF      (ceF),
		.smpcCe   (smpcCe),
		.mresN    (mresN)
	);

	busReadSteer u_busReadSteer (
		.cpuBusReq  (cpuBusReq),
		.chipSel    (chipSel),
		.memRdData  (memRdData),
		.scuRdData  (scuRdData),
		.smpcRdData (smpcRdData),
		.memWaitN   (memWaitN),
		.scuWaitN   (scuWaitN),
		.bBusSel    (bBusSel),
		.vdp1RdData (vdp1RdData),
		.vdp2RdData (vdp2RdData),
		.scspRdData (scspRdData),
		.memPort    (memPort),
		.cpuRdData  (cpuRdData),
		.cpuWaitN   (cpuWaitN),
		.bBusRdData (bBusRdData)
	);

	// Debug view of the master bus
	busActivityMonitor u_busActivityMonitor (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ceR       (ceR),
		.cpuBusReq (cpuBusReq),
		.waitCnt   (waitCnt),
		.hook      (hook)
	);

endmodule

`default_nettype wire

// File: tbTasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

logic [waitCntWidth-1:0] expIdle;
logic                    expHook;

task automatic check(input string testName, input logic [63:0] expected,
                     input logic [63:0] actual);
	if (expected !== actual) begin
		errorCount++;
		$display("[ERROR] %s: expected %0h, actual %0h", testName, expected, actual);
		$display("FAIL: see errors above");
		$fatal(1, "mismatch");
	end
endtask

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsrNext(input logic [15:0] state);
	logic feedback;
	feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
	return {state[14:0], feedback};
endfunction

task automatic randBits(input int count, output logic [31:0] bits);
	bits = '0;
	for (int i = 0; i < count; i++) begin
		lfsrState = lfsrNext(lfsrState);
		bits = {bits[30:0], lfsrState[0]};
	end
endtask

// Back to the drive point, 1 ns after the rising edge
task automatic tick();
	@(posedge CLK);
	#1;
endtask

task automatic idleBus();
	cpuBusReq = '0;
	cpuBusReq.bsN = 1'b1;
	cpuBusReq.cs0N = 1'b1;
	cpuBusReq.cs1N = 1'b1;
	cpuBusReq.cs2N = 1'b1;
	cpuBusReq.cs3N = 1'b1;
	cpuBusReq.rdWrN = 1'b1;
	cpuBusReq.rdN = 1'b1;
	cpuBusReq.dqmN = 4'hF;
	chipSel = '1;
	bBusSel = '1;
endtask

task automatic applyReset();
	RST_N = 1'b0;
	ce = 1'b0;
	dbgPause = 1'b0;
	idleBus();
	repeat (5) @(posedge CLK);
	#1;
	RST_N = 1'b1;
endtask

task automatic testResetState();
	#1;
	check("reset ceR", 64'd0, 64'(ceR));
	check("reset ceF", 64'd1, 64'(ceF));
	check("reset smpcCe", 64'd0, 64'(smpcCe));
	check("reset mresN", 64'd0, 64'(mresN));
	check("reset hook", 64'd0, 64'(hook));
	check("reset waitCnt", 64'd0, 64'(waitCnt));
	tick();
endtask

task automatic testPause();
	logic expPhase;
	expPhase = 1'b0;
	ce = 1'b1;
	for (int i = 0; i < 18; i++) begin
		dbgPause = (i >= 6 && i < 11);
		#1;
		check("pause ceR", 64'(expPhase && !dbgPause), 64'(ceR));
		check("pause ceF", 64'(!expPhase && !dbgPause), 64'(ceF));
		// Phase holds while paused
		if (!dbgPause) begin
			expPhase = !expPhase;
		end
		tick();
	end
	ce = 1'b0;
	dbgPause = 1'b0;
endtask

task automatic testSmpcEnable();
	int   ceRSeen;
	int   lastPulse;
	int   firstPulse;
	int   pulseCount;
	logic expMres;
	applyReset();
	ce = 1'b1;
	ceRSeen = 0;
	lastPulse = -1;
	firstPulse = -1;
	pulseCount = 0;
	for (int i = 0; i < 50; i++) begin
		#1;
		expMres = (firstPulse >= 0) && (i > firstPulse);
		check("smpc mresN", 64'(expMres), 64'(mresN));
		if (smpcCe) begin
			check("smpc ceR per pulse", 64'd7, 64'(ceRSeen));
			if (lastPulse >= 0) begin
				check("smpc spacing", 64'd14, 64'(i - lastPulse));
			end else begin
				firstPulse = i;
			end
			lastPulse = i;
			pulseCount++;
			ceRSeen = 0;
		end
		if (ceR) begin
			ceRSeen++;
		end
		tick();
	end
	check("smpc first pulse", 64'd14, 64'(firstPulse));
	check("smpc pulse count", 64'd3, 64'(pulseCount));
	ce = 1'b0;
endtask

task automatic testReadSteer();
	logic [31:0] memWord, scuWord, smpcBits, expData;
	logic        memSel;
	logic        expWait;
	// Bits: cs3N, dram, rom, sram, smpc, memWaitN, scuWaitN
	for (int combo = 0; combo < 128; combo++) begin
		randBits(32, memWord);
		randBits(32, scuWord);
		randBits(8, smpcBits);
		memRdData = memWord;
		scuRdData = scuWord;
		smpcRdData = smpcBits[7:0];
		cpuBusReq.cs3N = combo[0];
		chipSel.dramCeN = combo[1];
		chipSel.romCeN = combo[2];
		chipSel.sramCeN = combo[3];
		chipSel.smpcCeN = combo[4];
		memWaitN = combo[5];
		scuWaitN = combo[6];
		#1;
		memSel = !combo[0] || !combo[1] || !combo[2] || !combo[3];
		if (memSel) begin
			expData = memWord;
		end else if (!combo[4]) begin
			expData = {4{smpcBits[7:0]}};
		end else begin
			expData = scuWord;
		end
		expWait = combo[6] && (combo[5] || !memSel);
		check("read data", 64'(expData), 64'(cpuRdData));
		check("read wait", 64'(expWait), 64'(cpuWaitN));
		tick();
	end
	idleBus();
	memWaitN = 1'b1;
	scuWaitN = 1'b1;
endtask

task automatic testMemPortBBus();
	logic [31:0] addrBits, wrBits, dqmBits, ctlBits, ceBits, v1, v2, v3;
	logic [15:0] expB;
	for (int i = 0; i < 16; i++) begin
		randBits(25, addrBits);
		randBits(32, wrBits);
		randBits(4, dqmBits);
		randBits(2, ctlBits);
		randBits(4, ceBits);
		randBits(16, v1);
		randBits(16, v2);
		randBits(16, v3);
		cpuBusReq.addr = addrBits[24:0];
		cpuBusReq.wrData = wrBits;
		cpuBusReq.dqmN = dqmBits[3:0];
		cpuBusReq.rdN = ctlBits[0];
		cpuBusReq.cs3N = ctlBits[1];
		chipSel.dramCeN = ceBits[0];
		chipSel.romCeN = ceBits[1];
		chipSel.sramCeN = ceBits[2];
		chipSel.smpcCeN = ceBits[3];
		bBusSel.vdp1CsN = i[0];
		bBusSel.vdp2CsN = i[1];
		bBusSel.scspCsN = i[2];
		vdp1RdData = v1[15:0];
		vdp2RdData = v2[15:0];
		scspRdData = v3[15:0];
		#1;
		check("memPort addr", 64'(addrBits[24:0]), 64'(memPort.addr));
		check("memPort wrData", 64'(wrBits), 64'(memPort.wrData));
		check("memPort dqmN", 64'(dqmBits[3:0]), 64'(memPort.dqmN));
		check("memPort rdN", 64'(ctlBits[0]), 64'(memPort.rdN));
		check("memPort ramHCsN", 64'(ctlBits[1]), 64'(memPort.ramHCsN));
		check("memPort ramLCsN", 64'(ceBits[0]), 64'(memPort.ramLCsN));
		check("memPort romCsN", 64'(ceBits[1]), 64'(memPort.romCsN));
		check("memPort sramCsN", 64'(ceBits[2]), 64'(memPort.sramCsN));
		if (!i[0]) begin
			expB = v1[15:0];
		end else if (!i[1]) begin
			expB = v2[15:0];
		end else if (!i[2]) begin
			expB = v3[15:0];
		end else begin
			expB = '0;
		end
		check("bBus read data", 64'(expB), 64'(bBusRdData));
		tick();
	end
	idleBus();
endtask

// Checks the counter and hook each cycle against the bus that is driven
task automatic runMonitor(input int cycles, input string testName);
	logic access;
	logic hit;
	for (int i = 0; i < cycles; i++) begin
		#1;
		check({testName, " waitCnt"}, 64'(expIdle), 64'(waitCnt));
		check({testName, " hook"}, 64'(expHook), 64'(hook));
		access = !cpuBusReq.rdN || (cpuBusReq.dqmN != 4'hF);
		hit = (cpuBusReq.addr == hookAddr) && !cpuBusReq.rdN && !cpuBusReq.cs3N;
		if (ceR) begin
			if (access) begin
				expIdle = '0;
			end else begin
				expIdle = expIdle + 8'd1;
			end
			expHook = expHook || hit;
		end
		tick();
	end
endtask

task automatic testMonitor();
	applyReset();
	ce = 1'b1;
	expIdle = '0;
	expHook = 1'b0;
	runMonitor(530, "idle count");
	// 265 idle rising enables, past 255 and around to 9
	check("idle wrap", 64'd9, 64'(waitCnt));
	cpuBusReq.addr = 25'h000400;
	cpuBusReq.rdN = 1'b0;
	runMonitor(3, "read clear");
	idleBus();
	runMonitor(5, "idle after read");
	cpuBusReq.rdWrN = 1'b0;
	cpuBusReq.dqmN = 4'b1110;
	runMonitor(3, "byte write clear");
	idleBus();
	runMonitor(4, "idle after write");
	// Hook address read, but not through CS3
	cpuBusReq.addr = hookAddr;
	cpuBusReq.rdN = 1'b0;
	runMonitor(6, "hook miss");
	check("hook miss", 64'd0, 64'(hook));
	cpuBusReq.cs3N = 1'b0;
	runMonitor(3, "hook hit");
	check("hook hit", 64'd1, 64'(hook));
	idleBus();
	runMonitor(6, "hook sticky");
	check("hook sticky", 64'd1, 64'(hook));
	ce = 1'b0;
endtask

`endif

// File: tbSaturnGlue.sv
`timescale 1ns/10ps
`default_nettype none

module tbSaturnGlue;
	import saturnPkg::*;

	// All tests together run about 800 cycles
	localparam int timeoutCycles = 2000;

	logic                     CLK;
	logic                     RST_N;
	logic                     ce;
	logic                     dbgPause;
	logic                     ceR;
	logic                     ceF;
	logic                     smpcCe;
	logic                     mresN;
	cpuBusReqT                cpuBusReq;
	chipSelT                  chipSel;
	logic [cpuDataWidth-1:0]  memRdData;
	logic [cpuDataWidth-1:0]  scuRdData;
	logic [smpcDataWidth-1:0] smpcRdData;
	logic                     memWaitN;
	logic                     scuWaitN;
	memPortT                  memPort;
	logic [cpuDataWidth-1:0]  cpuRdData;
	logic                     cpuWaitN;
	bBusSelT                  bBusSel;
	logic [bBusDataWidth-1:0] vdp1RdData;
	logic [bBusDataWidth-1:0] vdp2RdData;
	logic [bBusDataWidth-1:0] scspRdData;
	logic [bBusDataWidth-1:0] bBusRdData;
	logic [waitCntWidth-1:0]  waitCnt;
	logic                     hook;

	int          errorCount;
	int          cycleCount;
	logic [15:0] lfsrState;

	saturnGlue u_dut (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.ce         (ce),
		.dbgPause   (dbgPause),
		.ceR        (ceR),
		.ceF        (ceF),
		.smpcCe     (smpcCe),
		.mresN      (mresN),
		.cpuBusReq  (cpuBusReq),
		.chipSel    (chipSel),
		.memRdData  (memRdData),
		.scuRdData  (scuRdData),
		.smpcRdData (smpcRdData),
		.memWaitN   (memWaitN),
		.scuWaitN   (scuWaitN),
		.memPort    (memPort),
		.cpuRdData  (cpuRdData),
		.cpuWaitN   (cpuWaitN),
		.bBusSel    (bBusSel),
		.vdp1RdData (vdp1RdData),
		.vdp2RdData (vdp2RdData),
		.scspRdData (scspRdData),
		.bBusRdData (bBusRdData),
		.waitCnt    (waitCnt),
		.hook       (hook)
	);

	`include "tbTasks.svh"

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
			$display("FAIL: see errors above");
			$fatal(1, "timeout");
		end
	end

	initial begin
		CLK = 1'b0;
		RST_N = 1'b0;
		ce = 1'b0;
		dbgPause = 1'b0;
		idleBus();
		memRdData = '0;
		scuRdData = '0;
		smpcRdData = '0;
		memWaitN = 1'b1;
		scuWaitN = 1'b1;
		vdp1RdData = '0;
		vdp2RdData = '0;
		scspRdData = '0;
		errorCount = 0;
		cycleCount = 0;
		lfsrState = 16'd22;

		applyReset();
		testResetState();
		testPause();
		testSmpcEnable();
		testReadSteer();
		testMemPortBBus();
		testMonitor();

		if (errorCount == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("FAIL: see errors above");
			$fatal(1, "errors were reported");
		end
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
saturnPkg.sv
clockEnableGen.sv
busReadSteer.sv
busActivityMonitor.sv
saturnGlue.sv
tbSaturnGlue.sv

// File: Makefile
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f tb.f --top-module tbSaturnGlue \
		-Mdir $(BUILD_DIR) -o simSaturnGlue
	./$(BUILD_DIR)/simSaturnGlue

clean:
	rm -rf $(BUILD_DIR)
